/* fog_loop.f */
logic/fog_loop_pkg.sv
logic/fog_regmap_pkg.sv
logic/fog_axil_regs.sv
logic/fog_mod_gen.sv
logic/fog_demod.sv
logic/fog_err_fir.sv
logic/fog_step_ramp.sv
logic/fog_loop_top.sv
bench/fog_loop_chk.sv
bench/fog_loop_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fog loop testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f fog_loop.f --top-module fog_loop_tb -o fog_loop_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/fog_loop_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation returned an error status"
	cat sim.log
	exit 1
fi

cat sim.log
if grep -qx "all tests passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* bench/fog_loop_tb.sv */
module fog_loop_tb import fog_loop_pkg::*, fog_regmap_pkg::*; ();

	localparam int OP_WR     = 0;
	localparam int OP_RD     = 1;  // equality check
	localparam int OP_RD_ANY = 2;  // just remember the value
	localparam int OP_RD_GT  = 3;  // signed, against last read
	localparam int OP_RD_LT  = 4;
	localparam int OP_RUN    = 5;  // constant adc
	localparam int OP_RUN_SQ = 6;  // adc stepped up in the high half
	localparam int OP_MOD    = 7;  // watch o_dac levels
	localparam int S_AWREADY = 0;
	localparam int S_BVALID  = 1;
	localparam int S_ARREADY = 2;
	localparam int S_RVALID  = 3;
	localparam int WAIT_LIMIT = 200;
	localparam int ADC_STEP   = 200;

	typedef struct {
		string     name;
		int        op;
		axi_addr_t addr;
		axi_data_t data;  // write data, swing for OP_MOD
		axi_data_t exp;
		axi_resp_t resp;
		adc_t      adc;
		int        cycles;  // run length, hold length for OP_MOD
	} entry_t;

	logic clk;
	logic arst_n;
	adc_t adc;
	axi_addr_t awaddr, araddr;
	axi_data_t wdata, rdata;
	logic [3:0] wstrb;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic awready, wready, bvalid, arready, rvalid;
	axi_resp_t bresp, rresp;
	dac_t dac;

	entry_t table_q[$];
	int checks = 0;
	int errors = 0;
	logic timed_out;  // stops the table after a stuck wait
	axi_data_t last_rd;

	fog_loop_top u_fog_loop_top (
		.CLOCK_DAC_1(clk), .i_arst_n(arst_n), .i_adc(adc),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .i_wdata(wdata), .i_wstrb(wstrb),
		.i_wvalid(wvalid), .i_bready(bready), .i_araddr(araddr),
		.i_arvalid(arvalid), .i_rready(rready),
		.o_awready(awready), .o_wready(wready), .o_bresp(bresp), .o_bvalid(bvalid),
		.o_arready(arready), .o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid),
		.o_dac(dac)
	);

	bind fog_loop_top fog_loop_chk u_fog_loop_chk (
		.i_clk(CLOCK_DAC_1), .i_arst_n(i_arst_n), .i_awvalid(i_awvalid),
		.i_awready(o_awready), .i_wready(o_wready), .i_bvalid(o_bvalid),
		.i_bready(i_bready), .i_arready(o_arready), .i_rvalid(o_rvalid),
		.i_rready(i_rready), .i_dac(o_dac)
	);

	always #10 clk = ~clk;  // 20 unit period

	task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected resp %b actual resp %b", name, exp, act);
		end
	endtask

	task automatic check_dac(input string name, input dac_t exp, input dac_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	task automatic note_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timeout while waiting for %s", what);
	endtask

	function automatic logic sig_now(input int sel);
		case (sel)
			S_AWREADY: return awready;
			S_BVALID:  return bvalid;
			S_ARREADY: return arready;
			S_RVALID:  return rvalid;
			default:   return 1'b0;
		endcase
	endfunction

	// sampled on the falling edge, away from the dut updates
	task automatic wait_high(input int sel, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!sig_now(sel) && n < WAIT_LIMIT);
		if (!sig_now(sel))
			note_timeout(what);
	endtask

	task automatic axi_write(input axi_addr_t a, input axi_data_t d, output axi_resp_t r);
		@(posedge clk);
		awaddr  <= a;
		wdata   <= d;
		wstrb   <= 4'hf;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		wait_high(S_AWREADY, "awready");
		if (timed_out)
			return;
		@(posedge clk);
		awvalid <= 1'b0;  // handshake taken on this edge
		wvalid  <= 1'b0;
		wait_high(S_BVALID, "bvalid");
		if (timed_out)
			return;
		r = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t a, output axi_data_t d, output axi_resp_t r);
		@(posedge clk);
		araddr  <= a;
		arvalid <= 1'b1;
		wait_high(S_ARREADY, "arready");
		if (timed_out)
			return;
		@(posedge clk);
		arvalid <= 1'b0;
		rready  <= 1'b1;
		wait_high(S_RVALID, "rvalid");
		if (timed_out)
			return;
		d = rdata;
		r = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic run_cycles(input adc_t base, input int n, input logic stepped);
		logic hi;
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			hi = u_fog_loop_top.high_half;  // settled between edges
			@(posedge clk);
			if (stepped && hi)
				adc <= base + adc_t'(ADC_STEP);
			else
				adc <= base;
		end
	endtask

	// measure hold lengths and swing of the bias levels on o_dac
	task automatic watch_mod(input entry_t e);
		dac_t vals [5];
		dac_t prev;
		dac_t swing;
		int n;
		@(negedge clk);
		prev = dac;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (dac == prev && n < WAIT_LIMIT);
		if (dac == prev) begin
			note_timeout("o_dac to change");
			return;
		end
		for (int k = 0; k < 5; k++) begin
			vals[k] = dac;
			if (k < 4) begin
				n = 0;
				do begin
					@(negedge clk);
					n++;
				end while (dac == vals[k] && n < WAIT_LIMIT);
				if (dac == vals[k]) begin
					note_timeout("the next o_dac level");
					return;
				end
				check_data({e.name, " hold"}, axi_data_t'(e.cycles), axi_data_t'(n));
			end
		end
		swing = (vals[0] - vals[1] == dac_t'(e.data)) ? vals[0] - vals[1] : vals[1] - vals[0];
		check_dac({e.name, " swing"}, dac_t'(e.data), swing);
		check_dac({e.name, " alternate"}, vals[0], vals[2]);
		check_dac({e.name, " alternate"}, vals[1], vals[3]);
	endtask

	task automatic add(input string name, input int op, input axi_addr_t a, input axi_data_t d,
			input axi_data_t exp, input axi_resp_t resp, input adc_t x, input int cycles);
		entry_t e;
		e.name = name;
		e.op = op;
		e.addr = a;
		e.data = d;
		e.exp = exp;
		e.resp = resp;
		e.adc = x;
		e.cycles = cycles;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		axi_addr_t regs [10];
		axi_data_t masks [10];
		axi_data_t rnd;
		regs = '{REG_FREQ_CNT, REG_AMP_H, REG_AMP_L, REG_POLARITY, REG_WAIT_CNT,
			REG_AVG_SEL, REG_ERR_OFFSET, REG_GAIN_SEL, REG_CONST_STEP, REG_FB_ON};
		masks = '{32'hffffffff, 32'hffffffff, 32'hffffffff, 32'h1, 32'hffffffff,
			32'h7, 32'hffffffff, 32'h1f, 32'hffffffff, 32'h1};
		// reset values
		foreach (regs[i])
			add("reset read", OP_RD, regs[i], 0, 0, RESP_OKAY, 0, 0);
		add("reset step", OP_RD, REG_STEP, 0, 0, RESP_OKAY, 0, 0);
		add("reset err_fir", OP_RD, REG_ERR_FIR, 0, 0, RESP_OKAY, 0, 0);
		// read only and unmapped
		add("write step", OP_WR, REG_STEP, 32'h1234, 0, RESP_SLVERR, 0, 0);
		add("step kept", OP_RD, REG_STEP, 0, 0, RESP_OKAY, 0, 0);
		add("write unmapped", OP_WR, 8'h30, 32'h55, 0, RESP_SLVERR, 0, 0);
		add("read unmapped", OP_RD, 8'h30, 0, 0, RESP_SLVERR, 0, 0);
		foreach (regs[i]) begin
			rnd = $urandom();
			add("reg write", OP_WR, regs[i], rnd, 0, RESP_OKAY, 0, 0);
			add("reg readback", OP_RD, regs[i], 0, rnd & masks[i], RESP_OKAY, 0, 0);
		end
		// modulation, open loop with zero step
		add("freq", OP_WR, REG_FREQ_CNT, 20, 0, RESP_OKAY, 0, 0);
		add("amp_h", OP_WR, REG_AMP_H, 32'h300, 0, RESP_OKAY, 0, 0);
		add("amp_l", OP_WR, REG_AMP_L, 32'h100, 0, RESP_OKAY, 0, 0);
		for (int i = 3; i < 10; i++)
			add("clear", OP_WR, regs[i], 0, 0, RESP_OKAY, 0, 0);
		add("flush", OP_RUN, 0, 0, 0, RESP_OKAY, 500, 100);  // ramp stops moving
		add("modulation", OP_MOD, 0, 32'h200, 0, RESP_OKAY, 500, 20);
		// filtered error from a constant offset
		add("offset", OP_WR, REG_ERR_OFFSET, 100, 0, RESP_OKAY, 0, 0);
		add("settle", OP_RUN, 0, 0, 0, RESP_OKAY, 500, 600);
		add("err_fir", OP_RD, REG_ERR_FIR, 0, (100 * 32766) >>> 15, RESP_OKAY, 0, 0);
		// feedback direction
		add("const", OP_WR, REG_CONST_STEP, 5, 0, RESP_OKAY, 0, 0);
		add("settle", OP_RUN, 0, 0, 0, RESP_OKAY, 500, 200);
		add("const step", OP_RD, REG_STEP, 0, 5, RESP_OKAY, 0, 0);
		add("offset zero", OP_WR, REG_ERR_OFFSET, 0, 0, RESP_OKAY, 0, 0);
		add("flush", OP_RUN, 0, 0, 0, RESP_OKAY, 500, 600);
		add("fb on", OP_WR, REG_FB_ON, 1, 0, RESP_OKAY, 0, 0);
		add("hold", OP_RUN, 0, 0, 0, RESP_OKAY, 500, 400);
		add("step held", OP_RD, REG_STEP, 0, 5, RESP_OKAY, 0, 0);
		add("offset pos", OP_WR, REG_ERR_OFFSET, 100, 0, RESP_OKAY, 0, 0);
		add("rise", OP_RUN, 0, 0, 0, RESP_OKAY, 500, 400);
		add("step rises", OP_RD_GT, REG_STEP, 0, 0, RESP_OKAY, 0, 0);
		add("polarity", OP_WR, REG_POLARITY, 1, 0, RESP_OKAY, 0, 0);
		add("step now", OP_RD_ANY, REG_STEP, 0, 0, RESP_OKAY, 0, 0);
		add("rise", OP_RUN, 0, 0, 0, RESP_OKAY, 500, 400);
		add("step rises inv", OP_RD_GT, REG_STEP, 0, 0, RESP_OKAY, 0, 0);
		// stepped adc, sign follows polarity
		add("offset zero", OP_WR, REG_ERR_OFFSET, 0, 0, RESP_OKAY, 0, 0);
		add("polarity off", OP_WR, REG_POLARITY, 0, 0, RESP_OKAY, 0, 0);
		add("wait", OP_WR, REG_WAIT_CNT, 4, 0, RESP_OKAY, 0, 0);
		add("step now", OP_RD_ANY, REG_STEP, 0, 0, RESP_OKAY, 0, 0);
		add("square", OP_RUN_SQ, 0, 0, 0, RESP_OKAY, 500, 600);
		add("step up", OP_RD_GT, REG_STEP, 0, 0, RESP_OKAY, 0, 0);
		add("polarity on", OP_WR, REG_POLARITY, 1, 0, RESP_OKAY, 0, 0);
		add("step now", OP_RD_ANY, REG_STEP, 0, 0, RESP_OKAY, 0, 0);
		add("square", OP_RUN_SQ, 0, 0, 0, RESP_OKAY, 500, 800);
		add("step down", OP_RD_LT, REG_STEP, 0, 0, RESP_OKAY, 0, 0);
	endtask

	task automatic apply(input entry_t e);
		axi_data_t d;
		axi_resp_t r;
		case (e.op)
			OP_WR: begin
				axi_write(e.addr, e.data, r);
				if (!timed_out)
					check_resp(e.name, e.resp, r);
			end
			OP_RUN, OP_RUN_SQ: run_cycles(e.adc, e.cycles, e.op == OP_RUN_SQ);
			OP_MOD: begin
				adc <= e.adc;
				watch_mod(e);
			end
			default: begin
				axi_read(e.addr, d, r);
				if (timed_out)
					return;
				check_resp(e.name, e.resp, r);
				if (e.op == OP_RD)
					check_data(e.name, e.exp, d);
				if (e.op == OP_RD_GT || e.op == OP_RD_LT) begin
					checks++;
					if ((e.op == OP_RD_GT) != ($signed(d) > $signed(last_rd)) || d == last_rd) begin
						errors++;
						$display("step moved the wrong way in %s: %0d then %0d",
							e.name, $signed(last_rd), $signed(d));
					end
				end
				last_rd = d;
			end
		endcase
	endtask

	initial begin
		void'($urandom(32'hc7b73e13));
		clk = 1'b0;
		arst_n = 1'b0;
		adc = '0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		last_rd = '0;
		timed_out = 1'b0;
		build_table();
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_dac("reset dac", '0, dac);
		foreach (table_q[i]) begin
			if (!timed_out)
				apply(table_q[i]);
		end
		finish_run();
	end

endmodule

/* bench/fog_loop_chk.sv */
module fog_loop_chk (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_awvalid,
	input logic i_awready,
	input logic i_wready,
	input logic i_bvalid,
	input logic i_bready,
	input logic i_arready,
	input logic i_rvalid,
	input logic i_rready,
	input logic [15:0] i_dac
);

	// response held until the master takes it
	bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_bvalid && !i_bready |=> i_bvalid)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_rvalid && !i_rready |=> i_rvalid)
		else $error("rvalid dropped before rready");

	awready_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(i_awready) |-> $past(i_awvalid))
		else $error("awready rose without awvalid");

	// address and data accepted in the same cycle
	wready_pair: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_wready == i_awready)
		else $error("wready and awready differ");

	// handshake outputs and dac quiet in reset
	reset_quiet: assert property (@(posedge i_clk) !i_arst_n |->
		!i_awready && !i_wready && !i_bvalid && !i_arready && !i_rvalid && i_dac == '0)
		else $error("outputs active during reset");

endmodule

/* logic/fog_loop_top.sv */
module fog_loop_top import fog_loop_pkg::*, fog_regmap_pkg::*; (
	input  logic                CLOCK_DAC_1,
	input  logic                i_arst_n,
	input  adc_t                i_adc,
	input  axi_addr_t           i_awaddr,
	input  logic                i_awvalid,
	input  axi_data_t           i_wdata,
	input  logic [AXI_DW/8-1:0] i_wstrb,
	input  logic                i_wvalid,
	input  logic                i_bready,
	input  axi_addr_t           i_araddr,
	input  logic                i_arvalid,
	input  logic                i_rready,
	output logic                o_awready,
	output logic                o_wready,
	output axi_resp_t           o_bresp,
	output logic                o_bvalid,
	output logic                o_arready,
	output axi_data_t           o_rdata,
	output axi_resp_t           o_rresp,
	output logic                o_rvalid,
	output dac_t                o_dac
);

	// settings from the register bank
	word_t      freq_cnt, amp_h, amp_l, wait_cnt, err_offset, const_step;
	logic       polarity, fb_on;
	logic [2:0] avg_sel;
	logic [4:0] gain_sel;
	// loop chain
	word_t      mod, err_fir, step;
	logic       high_half, switch_p, err_valid, fir_valid;
	adc_t       err;

	fog_axil_regs u_fog_axil_regs (
		.i_clk(CLOCK_DAC_1), .i_arst_n(i_arst_n),
		.i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
		.i_wvalid(i_wvalid), .i_bready(i_bready), .i_araddr(i_araddr),
		.i_arvalid(i_arvalid), .i_rready(i_rready),
		.o_awready(o_awready), .o_wready(o_wready), .o_bresp(o_bresp), .o_bvalid(o_bvalid),
		.o_arready(o_arready), .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid),
		.i_step(step), .i_err_fir(err_fir),  // readback
		.o_freq_cnt(freq_cnt), .o_amp_h(amp_h), .o_amp_l(amp_l), .o_polarity(polarity),
		.o_wait_cnt(wait_cnt), .o_avg_sel(avg_sel), .o_err_offset(err_offset),
		.o_gain_sel(gain_sel), .o_const_step(const_step), .o_fb_on(fb_on)
	);

	fog_mod_gen u_fog_mod_gen (
		.i_clk(CLOCK_DAC_1), .i_arst_n(i_arst_n),
		.i_freq_cnt(freq_cnt), .i_amp_h(amp_h), .i_amp_l(amp_l),
		.o_mod(mod), .o_high_half(high_half), .o_switch(switch_p)
	);

	fog_demod u_fog_demod (
		.i_clk(CLOCK_DAC_1), .i_arst_n(i_arst_n), .i_adc(i_adc),
		.i_high_half(high_half), .i_switch(switch_p), .i_wait_cnt(wait_cnt),
		.i_avg_sel(avg_sel), .i_polarity(polarity), .i_err_offset(err_offset),
		.o_err(err), .o_err_valid(err_valid)
	);

	fog_err_fir u_fog_err_fir (
		.i_clk(CLOCK_DAC_1), .i_arst_n(i_arst_n),
		.i_err(err), .i_err_valid(err_valid),
		.o_err_fir(err_fir), .o_fir_valid(fir_valid)
	);

	fog_step_ramp u_fog_step_ramp (
		.i_clk(CLOCK_DAC_1), .i_arst_n(i_arst_n),
		.i_err_fir(err_fir), .i_fir_valid(fir_valid), .i_fb_on(fb_on),
		.i_gain_sel(gain_sel), .i_const_step(const_step), .i_mod(mod),
		.o_step(step), .o_dac(o_dac)
	);

endmodule

/* logic/fog_step_ramp.sv */
module fog_step_ramp import fog_loop_pkg::*; (
	input  logic       i_clk,
	input  logic       i_arst_n,
	input  word_t      i_err_fir,
	input  logic       i_fir_valid,
	input  logic       i_fb_on,
	input  logic [4:0] i_gain_sel,
	input  word_t      i_const_step,
	input  word_t      i_mod,
	output word_t      o_step,
	output dac_t       o_dac
);

	dac_t  ramp;     // phase ramp, wraps at 2^16
	word_t err_gain;

	assign err_gain = i_err_fir >>> i_gain_sel;  // loop gain as a shift

	// integrator and ramp advance together on each filtered error
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_step <= '0;
			ramp   <= '0;
		end else if (i_fir_valid) begin
			if (i_fb_on)
				o_step <= o_step + err_gain;  // closed loop
			else
				o_step <= i_const_step;  // open loop
			ramp <= ramp + o_step[DAC_W-1:0];  // uses the step before update
		end
	end

	// ramp plus bias, one cycle behind the modulation
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_dac <= '0;
		else
			o_dac <= ramp + i_mod[DAC_W-1:0];
	end

endmodule

/* logic/fog_err_fir.sv */
module fog_err_fir import fog_loop_pkg::*; (
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  adc_t  i_err,
	input  logic  i_err_valid,
	output word_t o_err_fir,
	output logic  o_fir_valid
);

	adc_t  taps [FIR_TAPS];  // taps[0] newest
	adc_t  win  [FIR_TAPS];  // window including the incoming error
	word_t mac;

	always_comb begin
		win[0] = i_err;
		for (int k = 1; k < FIR_TAPS; k++)
			win[k] = taps[k-1];
	end

	// sum of products, fits in 32 bits for 14 bit data
	always_comb begin
		mac = '0;
		for (int k = 0; k < FIR_TAPS; k++)
			mac = mac + word_t'(win[k]) * word_t'(FIR_COEF[k]);
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int k = 0; k < FIR_TAPS; k++)
				taps[k] <= '0;  // delay line starts empty
			o_err_fir   <= '0;
			o_fir_valid <= 1'b0;
		end else begin
			o_fir_valid <= i_err_valid;
			if (i_err_valid) begin  // gated, once per modulation period
				for (int k = 0; k < FIR_TAPS; k++)
					taps[k] <= win[k];
				o_err_fir <= mac >>> FIR_SHIFT;
			end
		end
	end

endmodule

/* logic/fog_demod.sv */
module fog_demod import fog_loop_pkg::*; (
	input  logic       i_clk,
	input  logic       i_arst_n,
	input  adc_t       i_adc,
	input  logic       i_high_half,
	input  logic       i_switch,
	input  word_t      i_wait_cnt,
	input  logic [2:0] i_avg_sel,
	input  logic       i_polarity,
	input  word_t      i_err_offset,
	output adc_t       o_err,
	output logic       o_err_valid
);

	logic [WORD_W-1:0]        settle_cnt;  // samples skipped so far
	logic [4:0]               smp_cnt;     // samples summed so far
	logic [2:0]               sel;
	logic [4:0]               n_avg;
	logic                     take;
	word_t                    acc;
	word_t                    acc_cur;     // sum including this cycle's sample
	word_t                    avg_cur;
	word_t                    high_avg;    // kept from the high half
	logic signed [WORD_W+1:0] diff;
	logic signed [WORD_W+1:0] err_sum;

	always_comb begin
		sel     = (i_avg_sel > 3'(AVG_SEL_MAX)) ? 3'(AVG_SEL_MAX) : i_avg_sel;
		n_avg   = 5'd1 << sel;
		take    = (settle_cnt >= $unsigned(i_wait_cnt)) && (smp_cnt < n_avg);
		acc_cur = take ? acc + word_t'(i_adc) : acc;
		avg_cur = acc_cur >>> sel;  // divisor is 2^sel even on a short half
		diff    = high_avg - avg_cur;
		if (i_polarity)
			diff = -diff;
		err_sum = diff + i_err_offset;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			settle_cnt  <= '0;
			smp_cnt     <= '0;
			acc         <= '0;
			o_err_valid <= 1'b0;
		end else begin
			o_err_valid <= i_switch && !i_high_half;  // end of low half only
			if (i_switch) begin
				settle_cnt <= '0;  // restart for the next half
				smp_cnt    <= '0;
				acc        <= '0;
			end else begin
				if (settle_cnt < $unsigned(i_wait_cnt))
					settle_cnt <= settle_cnt + 1'b1;
				if (take)
					smp_cnt <= smp_cnt + 1'b1;
				acc <= acc_cur;
			end
		end
	end

	// high half average and error word
	always_ff @(posedge i_clk) begin
		if (i_switch && i_high_half)
			high_avg <= avg_cur;
		if (i_switch && !i_high_half) begin
			if (err_sum > ERR_MAX)
				o_err <= adc_t'(ERR_MAX);  // clip high
			else if (err_sum < ERR_MIN)
				o_err <= adc_t'(ERR_MIN);
			else
				o_err <= adc_t'(err_sum);
		end
	end

endmodule

/* logic/fog_mod_gen.sv */
module fog_mod_gen import fog_loop_pkg::*; (
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  word_t i_freq_cnt,
	input  word_t i_amp_h,
	input  word_t i_amp_l,
	output word_t o_mod,
	output logic  o_high_half,
	output logic  o_switch
);

	logic [WORD_W-1:0] cnt;       // cycles already spent in this half
	logic [WORD_W-1:0] half_len;
	logic [WORD_W-1:0] last_idx;  // index of the final cycle of a half

	assign half_len = (i_freq_cnt == '0) ? WORD_W'(1) : $unsigned(i_freq_cnt);  // zero acts as one
	assign last_idx = half_len - 1'b1;

	// o_switch is registered one step ahead, so it is high on cnt == last_idx
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt         <= '0;
			o_high_half <= 1'b1;  // start in the high half
			o_switch    <= 1'b0;
		end else if (o_switch) begin
			cnt         <= '0;
			o_high_half <= ~o_high_half;
			o_switch    <= (last_idx == '0);  // one cycle halves
		end else begin
			cnt      <= cnt + 1'b1;
			o_switch <= (cnt + 1'b1 >= last_idx);
		end
	end

	assign o_mod = o_high_half ? i_amp_h : i_amp_l;  // bias level

endmodule

/* logic/fog_axil_regs.sv */
module fog_axil_regs import fog_loop_pkg::*, fog_regmap_pkg::*; (
	input  logic                i_clk,
	input  logic                i_arst_n,
	input  axi_addr_t           i_awaddr,
	input  logic                i_awvalid,
	input  axi_data_t           i_wdata,
	input  logic [AXI_DW/8-1:0] i_wstrb,
	input  logic                i_wvalid,
	input  logic                i_bready,
	input  axi_addr_t           i_araddr,
	input  logic                i_arvalid,
	input  logic                i_rready,
	output logic                o_awready,
	output logic                o_wready,
	output axi_resp_t           o_bresp,
	output logic                o_bvalid,
	output logic                o_arready,
	output axi_data_t           o_rdata,
	output axi_resp_t           o_rresp,
	output logic                o_rvalid,
	input  word_t               i_step,
	input  word_t               i_err_fir,
	output word_t               o_freq_cnt,
	output word_t               o_amp_h,
	output word_t               o_amp_l,
	output logic                o_polarity,
	output word_t               o_wait_cnt,
	output logic [2:0]          o_avg_sel,
	output word_t               o_err_offset,
	output logic [4:0]          o_gain_sel,
	output word_t               o_const_step,
	output logic                o_fb_on
);

	axi_resp_t wr_resp;  // from awaddr
	axi_data_t rd_val;   // from araddr
	axi_resp_t rd_resp;

	// byte lane merge of new data over the old register value
	function automatic axi_data_t merge_strb(axi_data_t old_v, axi_data_t new_v,
			logic [AXI_DW/8-1:0] strb);
		axi_data_t res;
		res = old_v;
		for (int b = 0; b < AXI_DW/8; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_v[8*b +: 8];
		end
		return res;
	endfunction

	// write map: only the settings are writable
	always_comb begin
		case (i_awaddr)
			REG_FREQ_CNT, REG_AMP_H, REG_AMP_L, REG_POLARITY, REG_WAIT_CNT,
			REG_AVG_SEL, REG_ERR_OFFSET, REG_GAIN_SEL, REG_CONST_STEP,
			REG_FB_ON: wr_resp = RESP_OKAY;
			default:   wr_resp = RESP_SLVERR;  // unmapped or read only
		endcase
	end

	// read map, narrow fields zero extended
	always_comb begin
		rd_resp = RESP_OKAY;
		case (i_araddr)
			REG_FREQ_CNT:   rd_val = o_freq_cnt;
			REG_AMP_H:      rd_val = o_amp_h;
			REG_AMP_L:      rd_val = o_amp_l;
			REG_POLARITY:   rd_val = axi_data_t'(o_polarity);
			REG_WAIT_CNT:   rd_val = o_wait_cnt;
			REG_AVG_SEL:    rd_val = axi_data_t'(o_avg_sel);
			REG_ERR_OFFSET: rd_val = o_err_offset;
			REG_GAIN_SEL:   rd_val = axi_data_t'(o_gain_sel);
			REG_CONST_STEP: rd_val = o_const_step;
			REG_FB_ON:      rd_val = axi_data_t'(o_fb_on);
			REG_STEP:       rd_val = i_step;
			REG_ERR_FIR:    rd_val = i_err_fir;
			default: begin
				rd_val  = '0;
				rd_resp = RESP_SLVERR;
			end
		endcase
	end

	// write channel: ready pulse, then response
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_awready    <= 1'b0;
			o_wready     <= 1'b0;
			o_bvalid     <= 1'b0;
			o_bresp      <= RESP_OKAY;
			o_freq_cnt   <= '0;
			o_amp_h      <= '0;
			o_amp_l      <= '0;
			o_polarity   <= 1'b0;
			o_wait_cnt   <= '0;
			o_avg_sel    <= '0;
			o_err_offset <= '0;
			o_gain_sel   <= '0;
			o_const_step <= '0;
			o_fb_on      <= 1'b0;
		end else begin
			if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;  // response taken
			if (o_awready) begin  // handshake cycle
				o_awready <= 1'b0;
				o_wready  <= 1'b0;
				o_bvalid  <= 1'b1;
				o_bresp   <= wr_resp;
				case (i_awaddr)
					REG_FREQ_CNT:   o_freq_cnt   <= merge_strb(o_freq_cnt, i_wdata, i_wstrb);
					REG_AMP_H:      o_amp_h      <= merge_strb(o_amp_h, i_wdata, i_wstrb);
					REG_AMP_L:      o_amp_l      <= merge_strb(o_amp_l, i_wdata, i_wstrb);
					REG_POLARITY:   o_polarity   <= i_wstrb[0] ? i_wdata[0] : o_polarity;
					REG_WAIT_CNT:   o_wait_cnt   <= merge_strb(o_wait_cnt, i_wdata, i_wstrb);
					REG_AVG_SEL:    o_avg_sel    <= i_wstrb[0] ? i_wdata[2:0] : o_avg_sel;
					REG_ERR_OFFSET: o_err_offset <= merge_strb(o_err_offset, i_wdata, i_wstrb);
					REG_GAIN_SEL:   o_gain_sel   <= i_wstrb[0] ? i_wdata[4:0] : o_gain_sel;
					REG_CONST_STEP: o_const_step <= merge_strb(o_const_step, i_wdata, i_wstrb);
					REG_FB_ON:      o_fb_on      <= i_wstrb[0] ? i_wdata[0] : o_fb_on;
					default: ;  // slverr, nothing stored
				endcase
			end else if (i_awvalid && i_wvalid && !o_bvalid) begin
				o_awready <= 1'b1;  // held off while a response is pending
				o_wready  <= 1'b1;
			end
		end
	end

	// read channel
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_arready <= 1'b0;
			o_rvalid  <= 1'b0;
			o_rdata   <= '0;
			o_rresp   <= RESP_OKAY;
		end else begin
			if (o_rvalid && i_rready)
				o_rvalid <= 1'b0;
			if (o_arready) begin
				o_arready <= 1'b0;
				o_rvalid  <= 1'b1;
				o_rdata   <= rd_val;  // sampled at the handshake
				o_rresp   <= rd_resp;
			end else if (i_arvalid && !o_rvalid) begin
				o_arready <= 1'b1;
			end
		end
	end

endmodule

/* logic/fog_regmap_pkg.sv */
package fog_regmap_pkg;

	localparam int AXI_AW = 8;
	localparam int AXI_DW = 32;

	typedef logic [AXI_AW-1:0] axi_addr_t;
	typedef logic [AXI_DW-1:0] axi_data_t;
	typedef logic [1:0]        axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// loop settings, read/write
	localparam axi_addr_t REG_FREQ_CNT   = 8'h00;  // half period in clocks
	localparam axi_addr_t REG_AMP_H      = 8'h04;
	localparam axi_addr_t REG_AMP_L      = 8'h08;
	localparam axi_addr_t REG_POLARITY   = 8'h0C;  // bit 0
	localparam axi_addr_t REG_WAIT_CNT   = 8'h10;
	localparam axi_addr_t REG_AVG_SEL    = 8'h14;  // [2:0]
	localparam axi_addr_t REG_ERR_OFFSET = 8'h18;
	localparam axi_addr_t REG_GAIN_SEL   = 8'h1C;  // [4:0]
	localparam axi_addr_t REG_CONST_STEP = 8'h20;
	localparam axi_addr_t REG_FB_ON      = 8'h24;  // bit 0
	// readback, read only
	localparam axi_addr_t REG_STEP       = 8'h40;
	localparam axi_addr_t REG_ERR_FIR    = 8'h44;

endpackage

/* logic/fog_loop_pkg.sv */
package fog_loop_pkg;

	// widths along the signal path
	localparam int ADC_W  = 14;
	localparam int DAC_W  = 16;
	localparam int WORD_W = 32;

	typedef logic signed [ADC_W-1:0] adc_t;   // demodulated error uses the same range
	typedef logic [DAC_W-1:0]        dac_t;   // unsigned DAC code
	typedef logic signed [WORD_W-1:0] word_t;

	// error saturation bounds, full ADC range
	localparam int ERR_MAX = (2 ** (ADC_W - 1)) - 1;
	localparam int ERR_MIN = -(2 ** (ADC_W - 1));

	// 8 tap low pass on the error, symmetric, dc gain 32766/32768
	localparam int FIR_TAPS  = 8;
	localparam int FIR_SHIFT = 15;
	localparam logic signed [15:0] FIR_COEF [FIR_TAPS] = '{
		16'sd661, 16'sd2126, 16'sd5452, 16'sd8144,
		16'sd8144, 16'sd5452, 16'sd2126, 16'sd661
	};

	// 2^4 = 16 samples per half at most
	localparam int AVG_SEL_MAX = 4;

endpackage
